// File: dv/seg_display_tb.sv
module seg_display_tb;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int unsigned PAGE_TICKS  = 1999;
  localparam int unsigned SCAN_TICKS  = 9;
  localparam int unsigned PAGE_CYCLES = PAGE_TICKS + 1;
  localparam int unsigned SCAN_CYCLES = SCAN_TICKS + 1;
  localparam int unsigned ROT_CYCLES  = 3 * PAGE_CYCLES;
  localparam int unsigned NUM_ROT     = 11;  // rotation 0 only fills the results.
  localparam int unsigned RUN_CYCLES  = NUM_ROT * ROT_CYCLES;
  localparam int unsigned LIMIT       = (NUM_ROT + 1) * ROT_CYCLES + 1000;
  localparam int unsigned DRIVE_DLY   = 2;
  localparam logic [4:0]  MINUS       = 5'd16;
  localparam logic [4:0]  BLANK       = 5'd17;

  logic        clk;
  logic        rst_n;
  logic [6:0]  main_mode;
  logic [6:0]  sub_mode;
  logic [57:0] recv_cnt;
  logic [63:0] err_cnt;
  logic [3:0]  digit_sel;
  logic [7:0]  segments;

  // model state, glyph vectors are {dig3, dig2, dig1, dig0}.
  int unsigned cyc;
  logic        sel_on;
  logic        model_on;
  logic [15:0] lfsr_q;
  logic [19:0] main_pend;
  logic [19:0] main_show;
  logic [19:0] sub_pend;
  logic [19:0] sub_show;
  logic [19:0] ber_pend;
  logic [19:0] ber_show;
  logic [2:0]  ber_case_pend;  // 0 valid, then zero errors, zero bits, k over, m over.
  logic [2:0]  ber_case_show;
  logic [1:0]  exp_page;
  logic [3:0]  exp_sel;
  logic [4:0]  exp_glyph;
  logic [7:0]  exp_segs;
  logic        ber_ok;
  int unsigned ber_hits [5];
  int unsigned hex_hits;

  seg_display_top #(
    .PAGE_TICKS (PAGE_TICKS),
    .SCAN_TICKS (SCAN_TICKS)
  ) dut (
    .i_clk       (clk),
    .i_rst_n     (rst_n),
    .i_main_mode (main_mode),
    .i_sub_mode  (sub_mode),
    .i_recv_cnt  (recv_cnt),
    .i_err_cnt   (err_cnt),
    .o_digit_sel (digit_sel),
    .o_segments  (segments)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("Simulation FAILED");
    $fatal(1, "run stopped on the first error");
  endtask

  task automatic report_mismatch(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
    $display("Fail %s: got 0x%0h, expected 0x%0h", name, got, exp);
    stop_with_failure("a displayed value differs from the model");
  endtask

  function automatic logic [15:0] lfsr_next(input logic [15:0] state);
    return state[0] ? ((state >> 1) ^ 16'hb400) : (state >> 1);
  endfunction

  task automatic draw_bits(input int n, output logic [63:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      val    = {val[62:0], lfsr_q[0]};
      lfsr_q = lfsr_next(lfsr_q);
    end
  endtask

  // segment lines a..g in bits 0..6.
  function automatic logic [7:0] glyph_segments(input logic [4:0] g);
    case (g)
      5'd0:    return 8'b0011_1111;
      5'd1:    return 8'b0000_0110;
      5'd2:    return 8'b0101_1011;
      5'd3:    return 8'b0100_1111;
      5'd4:    return 8'b0110_0110;
      5'd5:    return 8'b0110_1101;
      5'd6:    return 8'b0111_1101;
      5'd7:    return 8'b0000_0111;
      5'd8:    return 8'b0111_1111;
      5'd9:    return 8'b0110_1111;
      5'd10:   return 8'b0111_0111;
      5'd11:   return 8'b0111_1100;
      5'd12:   return 8'b0011_1001;
      5'd13:   return 8'b0101_1110;
      5'd14:   return 8'b0111_1001;
      5'd15:   return 8'b0111_0001;
      5'd16:   return 8'b0100_0000;
      default: return 8'b0000_0000;
    endcase
  endfunction

  function automatic logic [19:0] mode_glyphs(input logic [6:0] v);
    return {BLANK, BLANK, 5'(v / 10), 5'(v % 10)};
  endfunction

  // ber is about m * 10^-(k+1), k is the count of x10 steps until err reaches recv.
  function automatic logic [22:0] ber_model(input logic [57:0] recv, input logic [63:0] err);
    logic [127:0] scaled;
    logic [127:0] m;
    int unsigned  k;
    logic [19:0]  dashes;
    dashes = {MINUS, MINUS, MINUS, MINUS};
    if (err == '0) return {3'd1, dashes};
    if (recv == '0) return {3'd2, dashes};
    scaled = 128'(err);
    k      = 0;
    while ((k <= 9) && (scaled < 128'(recv))) begin
      scaled = scaled * 10;
      k++;
    end
    if (k > 9) return {3'd3, dashes};
    m = (scaled * 10) / 128'(recv);
    if (m > 99) return {3'd4, dashes};
    return {3'd0, 5'(m / 10), 5'(m % 10), MINUS, 5'(k)};
  endfunction

  task automatic pick_ber_pair(input int unsigned idx, output logic [57:0] recv,
                               output logic [63:0] err);
    logic [63:0] r;
    case (idx)
      1: begin
        recv = 58'd1_000_000;
        err  = 64'd37;
      end
      2: begin
        recv = 58'd12_345;
        err  = 64'd0;
      end
      3: begin
        recv = 58'd0;
        err  = 64'd5;
      end
      4: begin
        recv = '1;
        err  = 64'd3;
      end
      5: begin
        recv = 58'd1000;
        err  = 64'd1000;
      end
      6: begin
        recv = 58'd7;
        err  = 64'd140;
      end
      7: begin
        recv = '1;
        err  = 64'h0080_0000_0000_0000;  // wide dividend path.
      end
      8: begin
        recv = 58'd2_000_000_000;
        err  = 64'd3;  // largest exponent still shown.
      end
      default: begin
        draw_bits(40, r);
        recv = 58'(r) | (58'd1 << 40);
        draw_bits(32, r);
        err = r;
      end
    endcase
  endtask

  task automatic drive_main(input int unsigned idx);
    logic [63:0] r;
    logic [6:0]  v;
    if (idx == 1) begin
      v = 7'd100;
    end else begin
      draw_bits(7, r);
      v = 7'(r % 100);
    end
    main_mode = v;
    main_pend = mode_glyphs(v);
  endtask

  task automatic drive_sub(input int unsigned idx);
    logic [63:0] r;
    logic [6:0]  v;
    if (idx == 1) begin
      v = 7'd127;
    end else begin
      draw_bits(7, r);
      v = 7'(r % 100);
    end
    sub_mode = v;
    sub_pend = mode_glyphs(v);
  endtask

  task automatic drive_ber(input int unsigned idx);
    logic [57:0] recv;
    logic [63:0] err;
    pick_ber_pair(idx, recv, err);
    recv_cnt = recv;
    err_cnt  = err;
    {ber_case_pend, ber_pend} = ber_model(recv, err);
  endtask

  // a value is sampled on the entry of the page before the one that shows it.
  task automatic advance_model();
    int unsigned phase;
    int unsigned rot;
    int unsigned sel_idx;
    logic [19:0] shown;
    phase = cyc % ROT_CYCLES;
    rot   = cyc / ROT_CYCLES;
    if (phase == 0) begin
      main_show = main_pend;
      if (cyc > 0) drive_sub(rot);
    end else if (phase == PAGE_CYCLES) begin
      sub_show = sub_pend;
      drive_ber(rot);
    end else if (phase == 2 * PAGE_CYCLES) begin
      ber_show      = ber_pend;
      ber_case_show = ber_case_pend;
      drive_main(rot + 1);
    end
    exp_page = 2'(2 - (cyc / PAGE_CYCLES) % 3);
    sel_idx  = (cyc / SCAN_CYCLES) % 4;
    case (exp_page)
      2'd2:    shown = main_show;
      2'd1:    shown = sub_show;
      default: shown = ber_show;
    endcase
    exp_glyph = shown[5 * sel_idx +: 5];
    exp_segs  = glyph_segments(exp_glyph);
    exp_sel   = 4'b0001 << sel_idx;
    ber_ok    = (ber_case_show == 3'd0);
    model_on  = (cyc >= ROT_CYCLES) && (cyc < RUN_CYCLES);
  endtask

  initial begin
    logic reached;
    rst_n     = 1'b0;
    main_mode = '0;
    sub_mode  = '0;
    recv_cnt  = '0;
    err_cnt   = '0;
    lfsr_q    = 16'd32598;
    sel_on    = 1'b0;
    model_on  = 1'b0;
    cyc       = 0;
    hex_hits  = 0;
    for (int i = 0; i < 5; i++) ber_hits[i] = 0;
    main_pend = mode_glyphs('0);
    sub_pend  = mode_glyphs('0);
    {ber_case_pend, ber_pend} = ber_model('0, '0);
    ber_show      = ber_pend;
    ber_case_show = ber_case_pend;
    sub_show      = sub_pend;
    repeat (4) @(posedge clk);
    #DRIVE_DLY;
    rst_n = 1'b1;
    advance_model();
    sel_on = 1'b1;
    while (cyc < RUN_CYCLES) begin
      @(posedge clk);
      #DRIVE_DLY;
      cyc++;
      advance_model();
    end
    reached = (hex_hits > 0);
    for (int i = 0; i < 5; i++) begin
      if (ber_hits[i] == 0) reached = 1'b0;
    end
    if (reached) begin
      $display("Simulation PASSED");
      $finish;
    end else begin
      stop_with_failure("the stimulus did not reach every display case");
    end
  end

  initial begin
    int unsigned ticks;
    ticks = 0;
    while (ticks < LIMIT) begin
      @(posedge clk);
      ticks++;
    end
    stop_with_failure("timeout, the run went past its cycle limit");
  end

  always @(negedge clk) begin
    if (model_on) begin
      if (exp_page == 2'd0) begin
        ber_hits[ber_case_show] <= ber_hits[ber_case_show] + 1;
      end else if ((exp_glyph >= 5'd10) && (exp_glyph <= 5'd15)) begin
        hex_hits <= hex_hits + 1;  // mode of 100 or more.
      end
    end
  end

  // all checks sample mid-cycle, clear of the drive edge.
  a_sel_onehot: assert property (@(negedge clk) disable iff (!sel_on) $onehot(digit_sel))
    else stop_with_failure("the digit select is not one-hot");

  a_sel_order: assert property (@(negedge clk) disable iff (!sel_on) digit_sel == exp_sel)
    else report_mismatch("o_digit_sel", 64'(digit_sel), 64'(exp_sel));

  a_dp_off: assert property (@(negedge clk) disable iff (!sel_on) segments[7] == 1'b0)
    else report_mismatch("o_segments[7]", 64'(segments[7]), 64'd0);

  a_mode_digit: assert property (@(negedge clk) disable iff (!model_on)
      (exp_page != 2'd0) |-> (segments == exp_segs))
    else report_mismatch("o_segments", 64'(segments), 64'(exp_segs));

  a_ber_digit: assert property (@(negedge clk) disable iff (!model_on)
      ((exp_page == 2'd0) && ber_ok) |-> (segments == exp_segs))
    else report_mismatch("o_segments", 64'(segments), 64'(exp_segs));

  a_ber_minus: assert property (@(negedge clk) disable iff (!model_on)
      ((exp_page == 2'd0) && !ber_ok) |-> (segments == 8'h40))
    else report_mismatch("o_segments", 64'(segments), 64'h40);

endmodule

// File: logic/ber_digits.sv
module ber_digits (
  input  logic               i_clk,
  input  logic               i_rst_n,
  input  logic               i_start,
  input  ber_pkg::recv_cnt_t i_recv_cnt,
  input  ber_pkg::err_cnt_t  i_err_cnt,
  output seg_pkg::glyph_t    o_dig0,
  output seg_pkg::glyph_t    o_dig1,
  output seg_pkg::glyph_t    o_dig2,
  output seg_pkg::glyph_t    o_dig3
);

  import ber_pkg::*;
  import seg_pkg::*;

  ber_state_t state_q;
  recv_cnt_t  recv_q;
  scaled_t    scaled_q;
  scaled_t    scaled_x10;
  scaled_t    quot;
  logic [3:0] k_q;          // decimal exponent found while scaling.
  logic       fail_q;
  logic       launch_q;
  logic       reached;
  logic       div_done;
  logic       bad_ratio;
  logic [6:0] m;
  glyph_t     dig0_q;
  glyph_t     dig1_q;
  glyph_t     dig2_q;
  glyph_t     dig3_q;

  assign scaled_x10 = (scaled_q << 3) + (scaled_q << 1);
  assign reached    = scaled_q >= scaled_t'(recv_q);
  assign m          = quot[6:0];
  assign bad_ratio  = fail_q || (quot > scaled_t'(99));

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      state_q  <= IDLE;
      k_q      <= '0;
      fail_q   <= 1'b0;
      launch_q <= 1'b0;
    end else begin
      launch_q <= 1'b0;
      unique case (state_q)
        IDLE: begin
          if (i_start) begin
            state_q <= SCALE;
            k_q     <= '0;
            fail_q  <= (i_recv_cnt == '0) || (i_err_cnt == '0);  // no ratio to show.
          end
        end
        SCALE: begin
          if (fail_q || (k_q > EXP_MAX)) begin
            fail_q  <= 1'b1;
            state_q <= DONE;
          end else if (reached) begin
            launch_q <= 1'b1;  // one more x10 lands this edge.
            state_q  <= DIVIDE;
          end else begin
            k_q <= k_q + 1'b1;
          end
        end
        DIVIDE: begin
          if (div_done) begin
            state_q <= DONE;
          end
        end
        DONE: state_q <= IDLE;
      endcase
    end
  end

  // every scaling cycle multiplies by ten, the exit cycle included.
  always_ff @(posedge i_clk) begin
    if ((state_q == IDLE) && i_start) begin
      recv_q   <= i_recv_cnt;
      scaled_q <= scaled_t'(i_err_cnt);
    end else if (state_q == SCALE) begin
      scaled_q <= scaled_x10;
    end
  end

  seq_divider #(
    .W_DEND ($bits(scaled_t)),
    .W_DSOR ($bits(recv_cnt_t))
  ) u_div (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_start    (launch_q),
    .i_dividend (scaled_q),
    .i_divisor  (recv_q),
    .o_busy     (),
    .o_done     (div_done),
    .o_quot     (quot),
    .o_rem      ()
  );

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      dig0_q <= GLYPH_BLANK;
      dig1_q <= GLYPH_BLANK;
      dig2_q <= GLYPH_BLANK;
      dig3_q <= GLYPH_BLANK;
    end else if (state_q == DONE) begin
      if (bad_ratio) begin
        dig0_q <= GLYPH_MINUS;
        dig1_q <= GLYPH_MINUS;
        dig2_q <= GLYPH_MINUS;
        dig3_q <= GLYPH_MINUS;
      end else begin
        dig3_q <= glyph_t'(m / 7'd10);  // mantissa tens.
        dig2_q <= glyph_t'(m % 7'd10);
        dig1_q <= GLYPH_MINUS;
        dig0_q <= {1'b0, k_q};
      end
    end
  end

  assign o_dig0 = dig0_q;
  assign o_dig1 = dig1_q;
  assign o_dig2 = dig2_q;
  assign o_dig3 = dig3_q;

endmodule

// File: logic/ber_pkg.sv
package ber_pkg;

  typedef logic [6:0]  mode_t;
  typedef logic [57:0] recv_cnt_t;
  typedef logic [63:0] err_cnt_t;
  typedef logic [99:0] scaled_t;   // error count times a power of ten.

  // largest exponent digit the display can show.
  localparam int unsigned EXP_MAX = 9;

  typedef enum logic [1:0] {
    IDLE,
    SCALE,
    DIVIDE,
    DONE
  } ber_state_t;

  // page index, counted down by the page counter.
  typedef logic [1:0] page_t;

  localparam page_t PAGE_MAIN = 2'd2;
  localparam page_t PAGE_SUB  = 2'd1;
  localparam page_t PAGE_BER  = 2'd0;

endpackage

// File: logic/digit_scanner.sv
module digit_scanner (
  input  logic                 i_clk,
  input  logic                 i_rst_n,
  input  seg_pkg::scan_ticks_t i_scan_ticks,
  input  seg_pkg::glyph_t      i_dig0,
  input  seg_pkg::glyph_t      i_dig1,
  input  seg_pkg::glyph_t      i_dig2,
  input  seg_pkg::glyph_t      i_dig3,
  output logic [3:0]           o_digit_sel,
  output seg_pkg::segs_t       o_segments
);

  import seg_pkg::*;

  logic       dwell_done;
  logic [3:0] sel_q;
  glyph_t     glyph;
  segs_t      enc;

  // dwell time per digit.
  down_counter #(
    .WIDTH ($bits(scan_ticks_t))
  ) u_dwell (
    .i_clk    (i_clk),
    .i_rst_n  (i_rst_n),
    .i_reload (i_scan_ticks),
    .i_dec    (1'b1),
    .o_zero   (dwell_done),
    .o_count  ()
  );

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      sel_q <= 4'b0001;
    end else if (dwell_done) begin
      sel_q <= {sel_q[2:0], sel_q[3]};
    end
  end

  always_comb begin
    case (sel_q)
      4'b0001: glyph = i_dig0;
      4'b0010: glyph = i_dig1;
      4'b0100: glyph = i_dig2;
      4'b1000: glyph = i_dig3;
      default: glyph = GLYPH_BLANK;
    endcase
  end

  assign enc         = encode_glyph(glyph);
  assign o_segments  = {1'b0, enc[6:0]};  // decimal point unused.
  assign o_digit_sel = sel_q;

endmodule

// File: logic/down_counter.sv
module down_counter #(
  parameter int WIDTH = 8
) (
  input  logic             i_clk,
  input  logic             i_rst_n,
  input  logic [WIDTH-1:0] i_reload,
  input  logic             i_dec,
  output logic             o_zero,
  output logic [WIDTH-1:0] o_count
);

  logic [WIDTH-1:0] count_q;

  // step taken at zero, the counter reloads on the same edge.
  assign o_zero  = i_dec && (count_q == '0);
  assign o_count = count_q;

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      count_q <= i_reload;
    end else if (i_dec) begin
      if (o_zero) begin
        count_q <= i_reload;
      end else begin
        count_q <= count_q - 1'b1;
      end
    end
  end

endmodule

// File: logic/seg_display_top.sv
module seg_display_top #(
  parameter int unsigned PAGE_TICKS = seg_pkg::PAGE_TICKS_DEF,
  parameter int unsigned SCAN_TICKS = seg_pkg::SCAN_TICKS_DEF
) (
  input  logic               i_clk,
  input  logic               i_rst_n,
  input  ber_pkg::mode_t     i_main_mode,
  input  ber_pkg::mode_t     i_sub_mode,
  input  ber_pkg::recv_cnt_t i_recv_cnt,
  input  ber_pkg::err_cnt_t  i_err_cnt,
  output logic [3:0]         o_digit_sel,
  output seg_pkg::segs_t     o_segments
);

  import seg_pkg::*;
  import ber_pkg::*;

  localparam int PAGE_W = $clog2(PAGE_TICKS + 1);

  logic       page_tick;
  page_t      page;
  page_t      page_q;
  logic       first_cycle;
  logic       start_main;
  logic       start_sub;
  logic       start_ber;
  logic [6:0] main_quot;
  logic [3:0] main_rem;
  logic [6:0] sub_quot;
  logic [3:0] sub_rem;
  glyph_t     ber_dig0;
  glyph_t     ber_dig1;
  glyph_t     ber_dig2;
  glyph_t     ber_dig3;
  glyph_t     dig0;
  glyph_t     dig1;
  glyph_t     dig2;
  glyph_t     dig3;

  down_counter #(
    .WIDTH (PAGE_W)
  ) u_page_tick (
    .i_clk    (i_clk),
    .i_rst_n  (i_rst_n),
    .i_reload (PAGE_W'(PAGE_TICKS)),
    .i_dec    (1'b1),
    .o_zero   (page_tick),
    .o_count  ()
  );

  // runs main, sub, ber and wraps.
  down_counter #(
    .WIDTH ($bits(page_t))
  ) u_page (
    .i_clk    (i_clk),
    .i_rst_n  (i_rst_n),
    .i_reload (PAGE_MAIN),
    .i_dec    (page_tick),
    .o_zero   (),
    .o_count  (page)
  );

  // 3 is never a page, so it marks the first cycle out of reset.
  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      page_q <= 2'd3;
    end else begin
      page_q <= page;
    end
  end

  assign first_cycle = (page_q == 2'd3);

  // each value is computed one page ahead of its display.
  assign start_main = first_cycle || ((page == PAGE_BER) && (page_q != PAGE_BER));
  assign start_sub  = first_cycle || ((page == PAGE_MAIN) && (page_q != PAGE_MAIN));
  assign start_ber  = first_cycle || ((page == PAGE_SUB) && (page_q != PAGE_SUB));

  seq_divider #(
    .W_DEND (7),
    .W_DSOR (4)
  ) u_div_main (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_start    (start_main),
    .i_dividend (i_main_mode),
    .i_divisor  (4'd10),
    .o_busy     (),
    .o_done     (),
    .o_quot     (main_quot),
    .o_rem      (main_rem)
  );

  seq_divider #(
    .W_DEND (7),
    .W_DSOR (4)
  ) u_div_sub (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_start    (start_sub),
    .i_dividend (i_sub_mode),
    .i_divisor  (4'd10),
    .o_busy     (),
    .o_done     (),
    .o_quot     (sub_quot),
    .o_rem      (sub_rem)
  );

  ber_digits u_ber (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_start    (start_ber),
    .i_recv_cnt (i_recv_cnt),
    .i_err_cnt  (i_err_cnt),
    .o_dig0     (ber_dig0),
    .o_dig1     (ber_dig1),
    .o_dig2     (ber_dig2),
    .o_dig3     (ber_dig3)
  );

  // tens above 9 show as a hex glyph.
  always_comb begin
    dig3 = GLYPH_BLANK;
    dig2 = GLYPH_BLANK;
    case (page)
      PAGE_MAIN: begin
        dig1 = {1'b0, main_quot[3:0]};
        dig0 = {1'b0, main_rem};
      end
      PAGE_SUB: begin
        dig1 = {1'b0, sub_quot[3:0]};
        dig0 = {1'b0, sub_rem};
      end
      PAGE_BER: begin
        dig3 = ber_dig3;
        dig2 = ber_dig2;
        dig1 = ber_dig1;
        dig0 = ber_dig0;
      end
      default: begin
        dig1 = GLYPH_BLANK;
        dig0 = GLYPH_BLANK;
      end
    endcase
  end

  digit_scanner u_scan (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_scan_ticks (scan_ticks_t'(SCAN_TICKS)),
    .i_dig0       (dig0),
    .i_dig1       (dig1),
    .i_dig2       (dig2),
    .i_dig3       (dig3),
    .o_digit_sel  (o_digit_sel),
    .o_segments   (o_segments)
  );

endmodule

// File: logic/seg_pkg.sv
package seg_pkg;

  typedef logic [4:0]  glyph_t;      // 0..15 hex, then minus and blank.
  typedef logic [7:0]  segs_t;       // {dp, g, f, e, d, c, b, a}.
  typedef logic [15:0] scan_ticks_t;

  localparam glyph_t GLYPH_MINUS = 5'd16;
  localparam glyph_t GLYPH_BLANK = 5'd17;

  localparam int unsigned SCAN_TICKS_DEF = 49;          // cycles per digit, minus one.
  localparam int unsigned PAGE_TICKS_DEF = 19_999_999;  // cycles per page, minus one.

  // active-high segment pattern of a glyph, decimal point off.
  function automatic segs_t encode_glyph(input glyph_t glyph);
    segs_t segs;
    case (glyph)
      5'd0:        segs = 8'h3f;
      5'd1:        segs = 8'h06;
      5'd2:        segs = 8'h5b;
      5'd3:        segs = 8'h4f;
      5'd4:        segs = 8'h66;
      5'd5:        segs = 8'h6d;
      5'd6:        segs = 8'h7d;
      5'd7:        segs = 8'h07;
      5'd8:        segs = 8'h7f;
      5'd9:        segs = 8'h6f;
      5'd10:       segs = 8'h77;
      5'd11:       segs = 8'h7c;  // lower case b.
      5'd12:       segs = 8'h39;
      5'd13:       segs = 8'h5e;  // lower case d.
      5'd14:       segs = 8'h79;
      5'd15:       segs = 8'h71;
      GLYPH_MINUS: segs = 8'h40;
      default:     segs = 8'h00;  // blank and unused codes.
    endcase
    return segs;
  endfunction

endpackage

// File: logic/seq_divider.sv
module seq_divider #(
  parameter int W_DEND = 8,
  parameter int W_DSOR = 8
) (
  input  logic              i_clk,
  input  logic              i_rst_n,
  input  logic              i_start,
  input  logic [W_DEND-1:0] i_dividend,
  input  logic [W_DSOR-1:0] i_divisor,
  output logic              o_busy,
  output logic              o_done,
  output logic [W_DEND-1:0] o_quot,
  output logic [W_DSOR-1:0] o_rem
);

  localparam int W_CNT = (W_DEND > 1) ? $clog2(W_DEND) : 1;

  logic              busy_q;
  logic              done_q;
  logic [W_CNT-1:0]  bit_cnt_q;
  logic [W_DEND-1:0] quot_q;     // dividend shifts out as quotient shifts in.
  logic [W_DSOR-1:0] rem_q;
  logic [W_DSOR-1:0] dsor_q;
  logic [W_DSOR:0]   trial;
  logic              fits;

  // partial remainder with the next dividend bit brought down.
  assign trial = {rem_q, quot_q[W_DEND-1]};
  assign fits  = trial >= {1'b0, dsor_q};

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      busy_q    <= 1'b0;
      done_q    <= 1'b0;
      bit_cnt_q <= '0;
    end else begin
      done_q <= 1'b0;
      if (busy_q) begin
        if (bit_cnt_q == '0) begin
          busy_q <= 1'b0;
          done_q <= 1'b1;  // quotient complete.
        end else begin
          bit_cnt_q <= bit_cnt_q - 1'b1;
        end
      end else if (i_start) begin
        busy_q    <= 1'b1;
        bit_cnt_q <= W_CNT'(W_DEND - 1);
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (!busy_q && i_start) begin
      quot_q <= i_dividend;
      rem_q  <= '0;
      dsor_q <= i_divisor;
    end else if (busy_q) begin
      quot_q <= {quot_q[W_DEND-2:0], fits};
      if (fits) begin
        rem_q <= W_DSOR'(trial - {1'b0, dsor_q});
      end else begin
        rem_q <= trial[W_DSOR-1:0];
      end
    end
  end

  assign o_busy = busy_q;
  assign o_done = done_q;
  assign o_quot = quot_q;
  assign o_rem  = rem_q;

endmodule

// File: project.f
logic/seg_pkg.sv
logic/ber_pkg.sv
logic/down_counter.sv
logic/seq_divider.sv
logic/ber_digits.sv
logic/digit_scanner.sv
logic/seg_display_top.sv
dv/seg_display_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the seven-segment display testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f project.f \
  --top-module seg_display_tb \
  -Mdir obj_dir \
  -o seg_display_sim
status=$?
if [ "$status" -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit "$status"
fi

./obj_dir/seg_display_sim
status=$?
if [ "$status" -ne 0 ]; then
  echo "simulation failed with status $status"
  exit "$status"
fi

exit 0
